// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= branchUnit_tb
FILELIST  ?= branchUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: branchUnit.f
hdl/branchPkg.sv
hdl/operandBypass.sv
hdl/branchDecide.sv
hdl/branchUnit.sv
test/branchUnit_sva.sv
test/branchUnit_check.sv
test/branchUnit_tb.sv

// File: hdl/branchDecide.sv
module branchDecide (
    input  logic                                 clk,
    input  logic                                 rst,
    input  branchPkg::branchReq_t                req,
    input  logic [branchPkg::DATA_WIDTH-1:0]     opA,
    input  logic [branchPkg::DATA_WIDTH-1:0]     opB,
    output branchPkg::redirect_t                 redirect
);

    import branchPkg::*;

    // Raw comparison results
    logic                     isEqual;
    logic                     ltSigned;
    logic                     ltUnsigned;

    // Outcome of the selected condition, before the branch flag
    logic                     condTrue;

    // Next-state values for the redirect register
    logic                     takenNext;
    logic [DATA_WIDTH-1:0]    targetNext;

    // Equality is shared by BEQ and BNE
    assign isEqual = (opA == opB);

    // Two's complement order for BLT and BGE
    assign ltSigned = ($signed(opA) < $signed(opB));

    // Plain bit-pattern order for BLTU and BGEU
    assign ltUnsigned = (opA < opB);

    // Each greater-or-equal case is the inverse of its less-than partner
    always_comb begin
        case (req.cond)
            BEQ:     condTrue = isEqual;
            BNE:     condTrue = !isEqual;
            BLT:     condTrue = ltSigned;
            BGE:     condTrue = !ltSigned;
            BLTU:    condTrue = ltUnsigned;
            BGEU:    condTrue = !ltUnsigned;
            // funct3 values 2 and 3 are not branches
            default: condTrue = 1'b0;
        endcase
    end

    assign takenNext = req.branch && condTrue;

    // PC-relative target, wraps modulo 2^32
    assign targetNext = req.pc + req.imm;

    // One cycle of latency from request to redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect <= '0;
        end
        else begin
            redirect.taken <= takenNext;
            // Hold the last target while no branch is in decode
            if (req.branch) begin
                redirect.target <= targetNext;
            end
        end
    end

endmodule

// File: hdl/branchPkg.sv
package branchPkg;

    // Machine word width of the RV32I datapath
    localparam int DATA_WIDTH = 32;

    // Architectural register index, x0 through x31
    typedef logic [4:0] regName_t;

    // x0 is hardwired to zero, so no stage may forward into it
    localparam regName_t ZERO_REG = 5'd0;

    // Branch condition, encoded as the funct3 field of the B-type instruction.
    // Codes 2 and 3 are unused by the ISA and resolve to not taken.
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchCond_t;

    // One later pipeline stage seen as a forwarding source
    typedef struct packed {
        logic                    regWrite;
        regName_t                rd;
        logic [DATA_WIDTH-1:0]   result;
    } fwdSource_t;

    // Branch request as produced by the decoder
    typedef struct packed {
        logic                    branch;
        branchCond_t             cond;
        logic [DATA_WIDTH-1:0]   pc;
        logic [DATA_WIDTH-1:0]   imm;
    } branchReq_t;

    // Redirect handed back to the fetch stage
    typedef struct packed {
        logic                    taken;
        logic [DATA_WIDTH-1:0]   target;
    } redirect_t;

endpackage

// File: hdl/branchUnit.sv
module branchUnit (
    input  logic                                 clk,
    input  logic                                 rst,

    // Branch request from decode
    input  branchPkg::branchReq_t                req,

    // Source register names and their register-file values
    input  branchPkg::regName_t                  rs1,
    input  branchPkg::regName_t                  rs2,
    input  logic [branchPkg::DATA_WIDTH-1:0]     read1,
    input  logic [branchPkg::DATA_WIDTH-1:0]     read2,

    // Results still in flight in later stages
    input  branchPkg::fwdSource_t                exFwd,
    input  branchPkg::fwdSource_t                memFwd,

    output branchPkg::redirect_t                 redirect
);

    import branchPkg::*;

    // Forwarded operands feeding the comparator
    logic [DATA_WIDTH-1:0]    opA;
    logic [DATA_WIDTH-1:0]    opB;

    // rs1 path
    operandBypass u_bypassA (
        .src     (rs1),
        .regVal  (read1),
        .exFwd   (exFwd),
        .memFwd  (memFwd),
        .operand (opA)
    );

    // rs2 path
    operandBypass u_bypassB (
        .src     (rs2),
        .regVal  (read2),
        .exFwd   (exFwd),
        .memFwd  (memFwd),
        .operand (opB)
    );

    // Condition check, target add and the redirect register
    branchDecide u_decide (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .opA      (opA),
        .opB      (opB),
        .redirect (redirect)
    );

endmodule

// File: hdl/operandBypass.sv
module operandBypass (
    input  branchPkg::regName_t                  src,
    input  logic [branchPkg::DATA_WIDTH-1:0]     regVal,
    input  branchPkg::fwdSource_t                exFwd,
    input  branchPkg::fwdSource_t                memFwd,
    output logic [branchPkg::DATA_WIDTH-1:0]     operand
);

    import branchPkg::*;

    // Which value ends up on the operand
    typedef enum logic [1:0] {
        SEL_REG = 2'd0,
        SEL_EX  = 2'd1,
        SEL_MEM = 2'd2
    } bypassSel_t;

    logic        exMatch;
    logic        memMatch;
    bypassSel_t  sel;

    // A stage hits when it writes, targets a real register and names our source
    assign exMatch  = exFwd.regWrite
                   && (exFwd.rd != ZERO_REG)
                   && (exFwd.rd == src);

    assign memMatch = memFwd.regWrite
                   && (memFwd.rd != ZERO_REG)
                   && (memFwd.rd == src);

    // Youngest producer wins, so execute takes priority over memory
    always_comb begin
        if (exMatch) begin
            sel = SEL_EX;
        end
        else if (memMatch) begin
            sel = SEL_MEM;
        end
        else begin
            sel = SEL_REG;
        end
    end

    always_comb begin
        case (sel)
            SEL_EX:  operand = exFwd.result;
            SEL_MEM: operand = memFwd.result;
            default: operand = regVal;
        endcase
    end

endmodule

// File: test/branchUnit_check.sv
module branchUnit_check (
    input  logic                     clk,
    input  branchPkg::redirect_t     redirect,
    input  logic                     expValid,
    input  logic [31:0]              expTest,
    input  logic                     expBranch,
    input  branchPkg::redirect_t     expRedirect
);

    timeunit 1ns;
    timeprecision 1ps;

    import branchPkg::*;

    // Expectation for one driven cycle
    // Test 0 marks a filler cycle
    typedef struct packed {
        logic [31:0]    test;
        logic           branch;
        redirect_t      result;
    } expect_t;

    expect_t pendingQ[$:1];

    // Target the redirect register holds, zero after reset
    logic [DATA_WIDTH-1:0] heldTarget = '0;

    int checkCount  = 0;
    int errorCount  = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int curTest     = 0;
    int curChecks   = 0;
    int curErrors   = 0;

    // Print the result of the test that just ended
    task closeTest();
        if (curTest != 0) begin
            if (curErrors == 0) begin
                $display("test %0d passed, %0d cycles checked", curTest, curChecks);
                testsPassed++;
            end
            else begin
                $display("test %0d failed, %0d of %0d cycles wrong", curTest, curErrors,
                         curChecks);
                testsFailed++;
            end
        end
        curChecks = 0;
        curErrors = 0;
    endtask

    task compareEntry(input expect_t e);
        logic                   bad;
        logic [DATA_WIDTH-1:0]  expTarget;
        bad = 1'b0;
        if (e.test != 0 && e.test != curTest) begin
            closeTest();
            curTest = e.test;
        end
        if (redirect.taken !== e.result.taken) begin
            $display("CHECK FAILED at %0d ns: test %0d taken is %0b, expected %0b",
                     $time, curTest, redirect.taken, e.result.taken);
            bad = 1'b1;
        end
        // Target only moves when a branch was presented
        expTarget  = e.branch ? e.result.target : heldTarget;
        heldTarget = expTarget;
        if (redirect.target !== expTarget) begin
            $display("CHECK FAILED at %0d ns: test %0d target is %h, expected %h",
                     $time, curTest, redirect.target, expTarget);
            bad = 1'b1;
        end
        checkCount++;
        curChecks++;
        if (bad) begin
            errorCount++;
            curErrors++;
        end
    endtask

    // Inputs held before this edge show up on redirect right after it
    always @(posedge clk) begin
        if (expValid) begin
            pendingQ.push_back({expTest, expBranch, expRedirect});
        end
    end

    // Redirect is settled by mid cycle
    always @(negedge clk) begin
        if (pendingQ.size() != 0) begin
            compareEntry(pendingQ.pop_front());
        end
    end

    task finishRun();
        closeTest();
        curTest = 0;
        $display("cycles checked %0d, wrong %0d, tests passed %0d, tests failed %0d",
                 checkCount, errorCount, testsPassed, testsFailed);
    endtask

endmodule

// File: test/branchUnit_sva.sv
module branchUnit_sva (
    input  logic                     clk,
    input  logic                     rst,
    input  branchPkg::branchReq_t    req,
    input  branchPkg::redirect_t     redirect
);

    timeunit 1ns;
    timeprecision 1ps;

    // Raw funct3 bits for the reserved codes
    logic [2:0] condBits;

    // Failed assertions, read back by the testbench
    int failCount = 0;

    assign condBits = req.cond;

    // Both taken and target clear on a reset edge
    resetClears: assert property (@(posedge clk) rst |=> (redirect == '0))
        else begin
            $error("redirect is not zero in the cycle after reset");
            failCount++;
        end

    noBranchNoTaken: assert property (@(posedge clk) disable iff (rst)
        !req.branch |=> !redirect.taken)
        else begin
            $error("taken follows a cycle without a branch request");
            failCount++;
        end

    // funct3 codes 2 and 3 are not branches
    reservedCondNotTaken: assert property (@(posedge clk) disable iff (rst)
        (condBits inside {3'd2, 3'd3}) |=> !redirect.taken)
        else begin
            $error("taken follows a cycle with a reserved condition code");
            failCount++;
        end

endmodule

bind branchDecide branchUnit_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .redirect (redirect)
);

// File: test/branchUnit_tb.sv
module branchUnit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import branchPkg::*;

    localparam int          CLK_PERIOD    = 40;
    localparam int          RESET_CYCLES  = 10;
    localparam int          MARGIN_CYCLES = 20;
    localparam int          MAX_VECTORS   = 64;
    // Hex words per line of the vectors file
    localparam int          FIELDS        = 17;
    localparam logic [31:0] SEED          = 32'he6a3_290b;
    localparam string       VECTOR_FILE   = "test/branch_vectors.txt";

    logic                   clk = 1'b0;
    logic                   rst;
    branchReq_t             req;
    regName_t               rs1;
    regName_t               rs2;
    logic [DATA_WIDTH-1:0]  read1;
    logic [DATA_WIDTH-1:0]  read2;
    fwdSource_t             exFwd;
    fwdSource_t             memFwd;
    redirect_t              redirect;

    // Expectation for the cycle being driven
    logic                   expValid;
    logic [31:0]            expTest;
    logic                   expBranch;
    redirect_t              expRedirect;

    logic [31:0]            vecMem [0:MAX_VECTORS*FIELDS-1];
    int                     numVectors = 0;
    logic                   loadDone = 1'b0;

    always #(CLK_PERIOD/2) clk = ~clk;

    branchUnit u_branchUnit (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rs1      (rs1),
        .rs2      (rs2),
        .read1    (read1),
        .read2    (read2),
        .exFwd    (exFwd),
        .memFwd   (memFwd),
        .redirect (redirect)
    );

    branchUnit_check u_check (
        .clk         (clk),
        .redirect    (redirect),
        .expValid    (expValid),
        .expTest     (expTest),
        .expBranch   (expBranch),
        .expRedirect (expRedirect)
    );

    // Vectors end at the first line with test number zero
    task loadVectors();
        foreach (vecMem[i]) vecMem[i] = '0;
        $readmemh(VECTOR_FILE, vecMem);
        while (numVectors < MAX_VECTORS && vecMem[numVectors*FIELDS] != 0) begin
            numVectors++;
        end
    endtask

    task automatic driveVector(input int idx);
        int base;
        base = idx * FIELDS;
        req.branch         <= vecMem[base+1][0];
        req.cond           <= branchCond_t'(vecMem[base+2][2:0]);
        rs1                <= vecMem[base+3][4:0];
        rs2                <= vecMem[base+4][4:0];
        read1              <= vecMem[base+5];
        read2              <= vecMem[base+6];
        exFwd.regWrite     <= vecMem[base+7][0];
        exFwd.rd           <= vecMem[base+8][4:0];
        exFwd.result       <= vecMem[base+9];
        memFwd.regWrite    <= vecMem[base+10][0];
        memFwd.rd          <= vecMem[base+11][4:0];
        memFwd.result      <= vecMem[base+12];
        req.pc             <= vecMem[base+13];
        req.imm            <= vecMem[base+14];
        expValid           <= 1'b1;
        expTest            <= vecMem[base];
        expBranch          <= vecMem[base+1][0];
        expRedirect.taken  <= vecMem[base+15][0];
        expRedirect.target <= vecMem[base+16];
    endtask

    // Random cycle with the branch flag low
    task automatic driveFiller();
        logic [31:0] rnd;
        rnd = $urandom();
        req.branch      <= 1'b0;
        req.cond        <= branchCond_t'(rnd[2:0]);
        rs1             <= rnd[7:3];
        rs2             <= rnd[12:8];
        exFwd.regWrite  <= rnd[13];
        memFwd.regWrite <= rnd[14];
        exFwd.rd        <= rnd[19:15];
        memFwd.rd       <= rnd[24:20];
        exFwd.result    <= $urandom();
        memFwd.result   <= $urandom();
        read1           <= $urandom();
        read2           <= $urandom();
        req.pc          <= $urandom();
        req.imm         <= $urandom();
        expValid        <= 1'b1;
        expTest         <= '0;
        expBranch       <= 1'b0;
        expRedirect     <= '0;
    endtask

    initial begin : stimulus
        int unsigned seedValue;
        int          prevTest;
        seedValue   = $urandom(SEED);
        rst         = 1'b1;
        req         = '0;
        rs1         = '0;
        rs2         = '0;
        read1       = '0;
        read2       = '0;
        exFwd       = '0;
        memFwd      = '0;
        expValid    = 1'b0;
        expTest     = '0;
        expBranch   = 1'b0;
        expRedirect = '0;
        loadVectors();
        loadDone = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        prevTest = -1;
        for (int i = 0; i < numVectors; i++) begin
            @(posedge clk);
            // One filler cycle between tests
            if (prevTest >= 0 && int'(vecMem[i*FIELDS]) != prevTest) begin
                driveFiller();
                @(posedge clk);
            end
            driveVector(i);
            prevTest = vecMem[i*FIELDS];
        end

        // Let the last redirect and a trailing filler drain through the checker
        @(posedge clk);
        driveFiller();
        @(posedge clk);
        expValid <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);

        u_check.finishRun();
        if (numVectors > 0 && u_check.checkCount > 0 && u_check.errorCount == 0
                && u_branchUnit.u_decide.u_sva.failCount == 0) begin
            $display("TEST OK");
        end
        else begin
            if (numVectors == 0) begin
                $display("No vectors could be read from %s", VECTOR_FILE);
            end
            if (u_branchUnit.u_decide.u_sva.failCount != 0) begin
                $display("%0d assertion failures on the redirect register",
                         u_branchUnit.u_decide.u_sva.failCount);
            end
            $display("TEST FAILED");
        end
        $finish;
    end

    // Two cycles per vector covers the filler cycles
    initial begin : watchdog
        wait (loadDone);
        #((numVectors * 2 + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("The run timed out at %0d ns before all vectors were checked", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: test/branch_vectors.txt
// test branch cond rs1 rs2 read1 read2 exWe exRd exRes memWe memRd memRes pc imm taken target
// All fields hex, target is not compared when branch is 0
1 0 0 01 02 0000002a 0000002a 0 00 00000000 0 00 00000000 00001000 00000040 0 00000000
1 0 4 03 04 fffffffb 00000003 1 03 00000001 0 00 00000000 00001004 00000010 0 00000000
1 0 7 05 06 00000009 00000001 0 00 00000000 1 05 00000009 00001008 00000020 0 00000000
2 1 0 01 02 0000002a 0000002a 0 00 00000000 0 00 00000000 00001000 00000040 1 00001040
2 1 0 01 02 0000002a 0000002b 0 00 00000000 0 00 00000000 00001004 00000040 0 00001044
2 1 1 01 02 0000002a 0000002b 0 00 00000000 0 00 00000000 00001008 fffffff8 1 00001000
2 1 1 01 02 0000002a 0000002a 0 00 00000000 0 00 00000000 0000100c 00000010 0 0000101c
2 1 4 01 02 fffffffb 00000003 0 00 00000000 0 00 00000000 00002000 00000100 1 00002100
2 1 4 01 02 00000007 00000007 0 00 00000000 0 00 00000000 00002004 00000008 0 0000200c
2 1 5 01 02 00000007 00000007 0 00 00000000 0 00 00000000 00002008 fffff000 1 00001008
2 1 5 01 02 00000003 fffffffb 0 00 00000000 0 00 00000000 0000200c 00000020 1 0000202c
2 1 5 01 02 fffffffb 00000003 0 00 00000000 0 00 00000000 00002010 00000004 0 00002014
2 1 6 01 02 00000003 fffffffb 0 00 00000000 0 00 00000000 fffffff0 00000020 1 00000010
2 1 6 01 02 00000003 00000003 0 00 00000000 0 00 00000000 00003000 00000004 0 00003004
2 1 7 01 02 fffffffb 00000003 0 00 00000000 0 00 00000000 00003004 000001fc 1 00003200
2 1 7 01 02 00000003 00000003 0 00 00000000 0 00 00000000 00003008 00000008 1 00003010
2 1 2 01 02 00000005 00000005 0 00 00000000 0 00 00000000 0000300c 00000004 0 00003010
2 1 3 01 02 00000005 00000006 0 00 00000000 0 00 00000000 00003010 00000004 0 00003014
3 1 4 01 02 80000000 00000001 0 00 00000000 0 00 00000000 00004000 00000010 1 00004010
3 1 6 01 02 80000000 00000001 0 00 00000000 0 00 00000000 00004004 00000010 0 00004014
3 1 5 01 02 80000000 00000001 0 00 00000000 0 00 00000000 00004008 00000010 0 00004018
3 1 7 01 02 80000000 00000001 0 00 00000000 0 00 00000000 0000400c 00000010 1 0000401c
4 1 0 05 06 00000001 00000009 1 05 00000009 0 00 00000000 00005000 00000080 1 00005080
4 1 0 05 06 00000011 00000022 1 06 00000011 0 00 00000000 00005004 00000080 1 00005084
4 1 0 07 08 00000000 00000005 1 09 00000005 1 07 00000005 00005008 0000000c 1 00005014
4 1 4 07 08 00000003 00000001 0 08 00000000 1 08 00000010 0000500c 00000004 1 00005010
4 1 0 0a 0b 00000000 00000064 1 0a 00000064 1 0a 00000001 00005010 00000100 1 00005110
4 1 1 0a 0b 00000007 00000000 1 0b 00000007 1 0b 00000008 00005014 00000008 0 0000501c
4 1 0 0c 0c 00000001 00000002 1 0c 00000005 0 00 00000000 00005018 00000004 1 0000501c
4 1 6 0d 0e ffffffff 00000000 1 0e 00000002 1 0d 00000001 0000501c 00000004 1 00005020
5 1 0 00 01 00000000 00000000 1 00 00000005 0 00 00000000 00006000 00000010 1 00006010
5 1 0 02 00 00000000 00000000 0 00 00000000 1 00 00000009 00006004 00000010 1 00006014
5 1 4 03 04 00000001 00000002 0 03 00000007 0 00 00000000 00006008 00000020 1 00006028
5 1 4 03 04 00000001 00000002 0 00 00000000 0 04 00000000 0000600c 00000020 1 0000602c
5 1 1 03 04 00000001 00000001 0 03 00000002 0 04 00000001 00006010 00000004 0 00006014
6 1 0 01 02 00000005 00000005 0 00 00000000 0 00 00000000 00007000 00000100 1 00007100
6 1 1 01 02 00000005 00000005 0 00 00000000 0 00 00000000 00007004 00000100 0 00007104
6 1 7 01 02 00000005 00000003 0 00 00000000 0 00 00000000 00007008 fffffff0 1 00006ff8
6 1 4 01 02 00000001 00000003 0 00 00000000 0 00 00000000 0000700c 00000008 1 00007014
6 1 1 01 02 00000001 00000003 0 00 00000000 0 00 00000000 00007010 0000000c 1 0000701c
